// ==== tb.f ====
+incdir+common
common/mips_isa_pkg.sv
common/exec_pkg.sv
rtl/instr_decoder.sv
rtl/ctrl_e.sv
rtl/alu.sv
xalu/xalu.sv
rtl/exec_stage.sv
bench/exec_stage_checker.sv
bench/exec_stage_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := exec_stage_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/exec_stage_tb.sv ====
`timescale 1ns/1ns
`include "mips_defs.svh"

module exec_stage_tb;
	import exec_pkg::*;

	localparam int n_alu = 200;
	localparam int n_ovf = 7;
	localparam int n_mov = 8;
	localparam int n_md = 16;
	localparam int n_mix = 150;
	localparam int n_total = n_alu + n_ovf + n_mov + n_md * 3 + 8 + n_mix;
	localparam int timeout_cycles = n_total * (`XALU_CYCLES + 6) + 100;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] ir;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic        out_valid;
	logic        out_ready;
	logic [31:0] result;
	logic        wr_en;
	logic [4:0]  wr_reg;
	exc_e        exc;

	logic [31:0] stim_lfsr;
	logic [31:0] bp_state;
	logic        bp_on;
	logic [31:0] ref_hi;
	logic [31:0] ref_lo;
	logic [31:0] ir_q[$];
	logic [31:0] rs_q[$];
	logic [31:0] rt_q[$];
	string       name_q[$];
	int          errors;
	int          idle_errors;
	int          checked;
	int          sent;
	int          cycles;

	logic [5:0] alu_fn[16] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
		`FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV,
		`FN_SRLV, `FN_SRAV};
	logic [5:0] alu_imm_op[8] = '{`OP_ADDI, `OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI,
		`OP_LUI, `OP_SLTI, `OP_SLTIU};
	logic [5:0] md_fn[4] = '{`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};

	exec_stage exec_stage_i (
		.clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready), .ir(ir),
		.rs_val(rs_val), .rt_val(rt_val), .out_valid(out_valid), .out_ready(out_ready),
		.result(result), .wr_en(wr_en), .wr_reg(wr_reg), .exc(exc)
	);

	bind exec_stage exec_stage_checker exec_stage_checker_i (
		.clk(clk), .arst_n(arst_n), .out_valid(out_valid), .out_ready(out_ready),
		.result(result), .wr_en(wr_en), .wr_reg(wr_reg), .exc(exc)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// taps of x^32 + x^22 + x^2 + x + 1 in the right-shifting form.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {`OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] random_alu_word();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sh;
		logic [15:0] imm;
		rs = 5'(rand_bits(5));
		rt = 5'(rand_bits(5));
		rd = 5'(rand_bits(5));
		sh = 5'(rand_bits(5));
		imm = 16'(rand_bits(16));
		if (rand_bits(1) == 32'h1)
			return r_word(alu_fn[4'(rand_bits(4))], rs, rt, rd, sh);
		return i_word(alu_imm_op[3'(rand_bits(3))], rs, rt, imm);
	endfunction

	// expected outcome of one instruction with its own copy of hi and lo.
	function automatic void predict(input logic [31:0] w, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] res, output logic we,
		output logic [4:0] rd_o, output exc_e ex);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  sh;
		logic [31:0] sx;
		logic [31:0] zx;
		logic        ov;
		longint      sa;
		longint      sb;
		logic [63:0] p;
		op = w[`F_OP];
		fn = w[`F_FUNCT];
		sh = w[`F_SHAMT];
		sx = {{16{w[15]}}, w[15:0]};
		zx = {16'h0, w[15:0]};
		sa = $signed(a);
		sb = $signed(b);
		res = 32'h0;
		we = 1'b1;
		ov = 1'b0;
		ex = exc_none;
		rd_o = (op == `OP_SPECIAL) ? w[`F_RD] : w[`F_RT];
		if (op == `OP_SPECIAL) begin
			case (fn)
				`FN_ADD, `FN_ADDU: begin
					res = a + b;
					ov = (fn == `FN_ADD) && (a[31] == b[31]) && (res[31] != a[31]);
				end
				`FN_SUB, `FN_SUBU: begin
					res = a - b;
					ov = (fn == `FN_SUB) && (a[31] != b[31]) && (res[31] != a[31]);
				end
				`FN_AND: res = a & b;
				`FN_OR: res = a | b;
				`FN_XOR: res = a ^ b;
				`FN_NOR: res = ~(a | b);
				`FN_SLT: res = {31'h0, $signed(a) < $signed(b)};
				`FN_SLTU: res = {31'h0, a < b};
				`FN_SLL: res = b << sh;
				`FN_SRL: res = b >> sh;
				`FN_SRA: res = $signed(b) >>> sh;
				`FN_SLLV: res = b << a[4:0];
				`FN_SRLV: res = b >> a[4:0];
				`FN_SRAV: res = $signed(b) >>> a[4:0];
				`FN_MOVZ: begin
					res = a;
					we = (b == 32'h0);
				end
				`FN_MOVN: begin
					res = a;
					we = (b != 32'h0);
				end
				`FN_MFHI: res = ref_hi;
				`FN_MFLO: res = ref_lo;
				default: we = 1'b0;
			endcase
			case (fn)
				`FN_MTHI: ref_hi = a;
				`FN_MTLO: ref_lo = a;
				`FN_MULT, `FN_MULTU: begin
					p = (fn == `FN_MULT) ? 64'(sa * sb) : ({32'h0, a} * {32'h0, b});
					ref_hi = p[63:32];
					ref_lo = p[31:0];
				end
				`FN_DIV, `FN_DIVU: begin
					if (b == 32'h0) begin
						ex = exc_div_zero; // hi and lo stay as they were.
					end else if (fn == `FN_DIV) begin
						ref_lo = 32'(sa / sb);
						ref_hi = 32'(sa % sb);
					end else begin
						ref_lo = a / b;
						ref_hi = a % b;
					end
				end
				default: ;
			endcase
		end else begin
			case (op)
				`OP_ADDI, `OP_ADDIU: begin
					res = a + sx;
					ov = (op == `OP_ADDI) && (a[31] == sx[31]) && (res[31] != a[31]);
				end
				`OP_SLTI: res = {31'h0, $signed(a) < $signed(sx)};
				`OP_SLTIU: res = {31'h0, a < sx};
				`OP_ANDI: res = a & zx;
				`OP_ORI: res = a | zx;
				`OP_XORI: res = a ^ zx;
				`OP_LUI: res = {w[15:0], 16'h0};
				default: we = 1'b0;
			endcase
		end
		if (ov)
			ex = exc_overflow;
		if (ex != exc_none)
			we = 1'b0;
	endfunction

	task automatic report_mismatch(input string test, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("** Error %s: %s expected 0x%08h, actual 0x%08h", test, field, expected,
			actual);
		errors++;
	endtask

	// holds the item on the inputs until the DUT takes it.
	task automatic send(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
		input string name);
		in_valid = 1'b1;
		ir = w;
		rs_val = a;
		rt_val = b;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		ir_q.push_back(w);
		rs_q.push_back(a);
		rt_q.push_back(b);
		name_q.push_back(name);
		sent++;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	initial begin
		out_ready = 1'b1;
		bp_state = 32'h1644_0044;
		forever begin
			@(posedge clk);
			#2;
			if (bp_on) begin
				bp_state = lfsr_step(bp_state);
				out_ready = bp_state[0];
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	always @(negedge clk) begin
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] e_res;
		logic        e_we;
		logic [4:0]  e_rd;
		exc_e        e_ex;
		string       name;
		if (arst_n && out_valid && out_ready) begin
			if (ir_q.size() == 0) begin
				$display("An output item appeared with no instruction outstanding");
				errors++;
			end else begin
				w = ir_q.pop_front();
				a = rs_q.pop_front();
				b = rt_q.pop_front();
				name = name_q.pop_front();
				predict(w, a, b, e_res, e_we, e_rd, e_ex);
				if (wr_en !== e_we)
					report_mismatch(name, "wr_en", 32'(e_we), 32'(wr_en));
				if (exc !== e_ex)
					report_mismatch(name, "exc", 32'(e_ex), 32'(exc));
				if (e_we && result !== e_res)
					report_mismatch(name, "result", e_res, result);
				if (e_we && wr_reg !== e_rd)
					report_mismatch(name, "wr_reg", 32'(e_rd), 32'(wr_reg));
			end
			checked++;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d items still outstanding", cycles, ir_q.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		int          lost;
		int          assert_fails;
		stim_lfsr = 32'h1644_0044;
		arst_n = 1'b0;
		in_valid = 1'b0;
		ir = 32'h0;
		rs_val = 32'h0;
		rt_val = 32'h0;
		bp_on = 1'b0;
		ref_hi = 32'h0;
		ref_lo = 32'h0;
		errors = 0;
		idle_errors = 0;
		checked = 0;
		sent = 0;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (10) begin
			@(negedge clk);
			if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
				$display("DUT not idle after reset: out_valid %0b, in_ready %0b", out_valid,
					in_ready);
				idle_errors++;
			end
		end
		@(posedge clk);
		#2;

		for (int k = 0; k < n_alu; k++)
			send(random_alu_word(), rand_bits(32), rand_bits(32), "alu_random");

		send(r_word(`FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0), 32'h7fff_ffff, 32'h1, "overflow");
		send(r_word(`FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 32'h7fff_ffff, 32'h1, "overflow");
		send(r_word(`FN_ADD, 5'd1, 5'd2, 5'd4, 5'd0), 32'h8000_0000, 32'hffff_ffff, "overflow");
		send(r_word(`FN_SUB, 5'd1, 5'd2, 5'd5, 5'd0), 32'h8000_0000, 32'h1, "overflow");
		send(r_word(`FN_SUBU, 5'd1, 5'd2, 5'd5, 5'd0), 32'h8000_0000, 32'h1, "overflow");
		send(i_word(`OP_ADDI, 5'd1, 5'd6, 16'h0001), 32'h7fff_ffff, 32'h0, "overflow");
		send(i_word(`OP_ADDIU, 5'd1, 5'd6, 16'h0001), 32'h7fff_ffff, 32'h0, "overflow");

		for (int k = 0; k < n_mov / 2; k++) begin
			b = (k % 2 == 0) ? 32'h0 : (rand_bits(32) | 32'h1);
			a = rand_bits(32);
			send(r_word(`FN_MOVZ, 5'd7, 5'd8, 5'(rand_bits(5)), 5'd0), a, b, "cond_move");
			send(r_word(`FN_MOVN, 5'd7, 5'd8, 5'(rand_bits(5)), 5'd0), a, b, "cond_move");
		end

		for (int k = 0; k < n_md; k++) begin
			w = r_word(md_fn[2'(rand_bits(2))], 5'd1, 5'd2, 5'd0, 5'd0);
			a = rand_bits(32);
			b = (k % 2 == 0) ? rand_bits(32) : (rand_bits(8) + 32'h1); // small divisors too.
			send(w, a, b, "mul_div");
			send(r_word(`FN_MFHI, 5'd0, 5'd0, 5'(rand_bits(5)), 5'd0), 32'h0, 32'h0, "mul_div");
			send(r_word(`FN_MFLO, 5'd0, 5'd0, 5'(rand_bits(5)), 5'd0), 32'h0, 32'h0, "mul_div");
		end
		send(r_word(`FN_MTHI, 5'd1, 5'd0, 5'd0, 5'd0), 32'h1234_5678, 32'h0, "hi_lo_moves");
		send(r_word(`FN_MTLO, 5'd1, 5'd0, 5'd0, 5'd0), 32'h9abc_def0, 32'h0, "hi_lo_moves");
		send(r_word(`FN_MFHI, 5'd0, 5'd0, 5'd9, 5'd0), 32'h0, 32'h0, "hi_lo_moves");
		send(r_word(`FN_MFLO, 5'd0, 5'd0, 5'd10, 5'd0), 32'h0, 32'h0, "hi_lo_moves");
		send(r_word(`FN_DIV, 5'd1, 5'd2, 5'd0, 5'd0), 32'h55, 32'h0, "div_zero");
		send(r_word(`FN_DIVU, 5'd1, 5'd2, 5'd0, 5'd0), 32'h77, 32'h0, "div_zero");
		send(r_word(`FN_MFHI, 5'd0, 5'd0, 5'd11, 5'd0), 32'h0, 32'h0, "div_zero");
		send(r_word(`FN_MFLO, 5'd0, 5'd0, 5'd12, 5'd0), 32'h0, 32'h0, "div_zero");

		bp_on = 1'b1;
		for (int k = 0; k < n_mix; k++) begin
			case (3'(rand_bits(3)))
				3'd4: w = i_word(6'h23, 5'(rand_bits(5)), 5'(rand_bits(5)), 16'(rand_bits(16)));
				3'd5: w = r_word(md_fn[2'(rand_bits(2))], 5'd1, 5'd2, 5'd0, 5'd0);
				3'd6: w = r_word((rand_bits(1) == 32'h1) ? `FN_MFHI : `FN_MFLO, 5'd0, 5'd0,
					5'(rand_bits(5)), 5'd0);
				3'd7: w = r_word((rand_bits(1) == 32'h1) ? `FN_MOVZ : `FN_MOVN, 5'd1, 5'd2,
					5'(rand_bits(5)), 5'd0);
				default: w = random_alu_word();
			endcase
			a = rand_bits(32);
			b = (rand_bits(2) == 32'h0) ? 32'h0 : rand_bits(32);
			send(w, a, b, "mixed_backpressure");
		end

		while (ir_q.size() != 0)
			@(negedge clk);
		bp_on = 1'b0;
		repeat (4) @(negedge clk);
		lost = (checked != sent) ? 1 : 0;
		assert_fails = exec_stage_i.exec_stage_checker_i.fails;
		if (lost != 0)
			$display("Sent %0d items but %0d came out", sent, checked);
		$display("Sent %0d, compared %0d, mismatches %0d, idle errors %0d, count errors %0d, %s %0d",
			sent, checked, errors, idle_errors, lost, "assertion failures", assert_fails);
		if (errors == 0 && idle_errors == 0 && lost == 0 && assert_fails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== bench/exec_stage_checker.sv ====
`timescale 1ns/1ns

module exec_stage_checker (
	input logic           clk,
	input logic           arst_n,
	input logic           out_valid,
	input logic           out_ready,
	input logic [31:0]    result,
	input logic           wr_en,
	input logic [4:0]     wr_reg,
	input exec_pkg::exc_e exc
);
	import exec_pkg::*;

	int fails = 0;

	// the output register is cleared while reset is held.
	reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else begin
			fails++;
			$error("out_valid is high during reset");
		end

	hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable({result, wr_en, wr_reg, exc}))
		else begin
			fails++;
			$error("output item changed or vanished while stalled");
		end

	exc_no_write: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && (exc != exc_none) |-> !wr_en)
		else begin
			fails++;
			$error("faulting item has its write enable set");
		end

endmodule

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  logic [31:0]            ir,
	input  logic [31:0]            rs_val,
	input  logic [31:0]            rt_val,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic [31:0]            result,
	output logic                   wr_en,
	output mips_isa_pkg::reg_idx_t wr_reg,
	output exec_pkg::exc_e         exc
);
	import mips_isa_pkg::*;
	import exec_pkg::*;

	logic        s1_valid;
	instr_u      s1_ir;
	logic [31:0] s1_rs;
	logic [31:0] s1_rt;

	alu_op_e  d_alu_op;
	xalu_op_e d_xalu_op;
	res_sel_e d_res_sel;
	logic     d_b_imm;
	logic     d_imm_signed;
	logic     d_shift_var;
	logic     d_chk_ovf;
	logic     d_is_movz;
	logic     d_is_movn;
	logic     d_writes;
	reg_idx_t d_dest;
	logic [31:0] imm_ext;

	logic        s2_valid;
	logic        s2_issued; // the unit has already been started for this item.
	alu_op_e     s2_alu_op;
	xalu_op_e    s2_xalu_op;
	res_sel_e    s2_res_sel;
	logic        s2_chk_ovf;
	logic        s2_is_movz;
	logic        s2_is_movn;
	logic        s2_writes;
	reg_idx_t    s2_dest;
	logic [4:0]  s2_shamt;
	logic [31:0] s2_rs;
	logic [31:0] s2_b;
	logic [31:0] s2_rt;

	logic [31:0] alu_y;
	logic        alu_ovf;
	logic        c_xalu_start;
	logic        c_wr_en;
	exc_e        c_exc;
	logic        x_busy;
	logic [31:0] x_hi;
	logic [31:0] x_lo;
	logic        x_start;
	logic        x_wait;
	logic        s3_free;
	logic        s2_go;
	logic        s2_free;
	logic        s1_go;

	instr_decoder instr_decoder_i (
		.ir(s1_ir), .alu_op(d_alu_op), .xalu_op(d_xalu_op), .res_sel(d_res_sel),
		.b_imm(d_b_imm), .imm_signed(d_imm_signed), .shift_var(d_shift_var),
		.chk_ovf(d_chk_ovf), .is_movz(d_is_movz), .is_movn(d_is_movn),
		.dest(d_dest), .writes(d_writes)
	);

	ctrl_e ctrl_e_i (
		.alu_op(s2_alu_op), .xalu_op(s2_xalu_op), .chk_ovf(s2_chk_ovf),
		.is_movz(s2_is_movz), .is_movn(s2_is_movn), .writes(s2_writes),
		.rt_val(s2_rt), .alu_ovf(alu_ovf), .xalu_start(c_xalu_start),
		.wr_en(c_wr_en), .exc(c_exc)
	);

	alu alu_i (
		.op(s2_alu_op), .a(s2_rs), .b(s2_b), .shamt(s2_shamt), .y(alu_y), .ovf(alu_ovf)
	);

	xalu xalu_i (
		.clk(clk), .arst_n(arst_n), .start(x_start), .op(s2_xalu_op),
		.a(s2_rs), .b(s2_rt), .busy(x_busy), .hi(x_hi), .lo(x_lo)
	);

	assign x_start = s2_valid && c_xalu_start && !s2_issued;
	assign x_wait  = x_busy ||
	                 (x_start && (s2_xalu_op inside {xalu_mult, xalu_multu, xalu_div, xalu_divu}));

	// ready runs back from the output register.
	assign s3_free  = !out_valid || out_ready;
	assign s2_go    = s2_valid && !x_wait && s3_free;
	assign s2_free  = !s2_valid || s2_go;
	assign s1_go    = s1_valid && s2_free;
	assign in_ready = !s1_valid || s1_go;

	assign imm_ext = d_imm_signed ? {{16{s1_ir.i.imm[15]}}, s1_ir.i.imm} : {16'h0, s1_ir.i.imm};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			s2_issued <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (in_ready)
				s1_valid <= in_valid;
			if (s2_free)
				s2_valid <= s1_go;
			if (s3_free)
				out_valid <= s2_go;
			if (s2_go)
				s2_issued <= 1'b0;
			else if (x_start)
				s2_issued <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			s1_ir <= ir;
			s1_rs <= rs_val;
			s1_rt <= rt_val;
		end
		if (s1_go) begin
			s2_alu_op  <= d_alu_op;
			s2_xalu_op <= d_xalu_op;
			s2_res_sel <= d_res_sel;
			s2_chk_ovf <= d_chk_ovf;
			s2_is_movz <= d_is_movz;
			s2_is_movn <= d_is_movn;
			s2_writes  <= d_writes;
			s2_dest    <= d_dest;
			s2_shamt   <= d_shift_var ? s1_rs[4:0] : s1_ir.r.shamt;
			s2_rs      <= s1_rs;
			s2_rt      <= s1_rt;
			// a conditional move copies rs, so it takes the b path as well.
			s2_b <= d_b_imm ? imm_ext : ((d_is_movz || d_is_movn) ? s1_rs : s1_rt);
		end
		if (s2_go) begin
			case (s2_res_sel)
				res_hi: result <= x_hi;
				res_lo: result <= x_lo;
				default: result <= alu_y;
			endcase
			wr_en  <= c_wr_en;
			wr_reg <= s2_dest;
			exc    <= c_exc;
		end
	end

endmodule

// ==== xalu/xalu.sv ====
`timescale 1ns/1ns
`include "mips_defs.svh"

module xalu (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  exec_pkg::xalu_op_e op,
	input  logic [31:0]        a,
	input  logic [31:0]        b,
	output logic               busy,
	output logic [31:0]        hi,
	output logic [31:0]        lo
);
	import exec_pkg::*;

	localparam int cyc   = `XALU_CYCLES;
	localparam int steps = (32 + cyc - 1) / cyc; // bit steps done per cycle.
	localparam int cw    = $clog2(cyc + 1);

	logic [cw-1:0] cnt;
	logic [5:0]    nbits;
	logic [5:0]    nbits_n;
	logic          is_div;
	logic          neg_lo;
	logic          neg_hi;
	logic [63:0]   work;   // product, or remainder over quotient.
	logic [63:0]   work_n;
	logic [63:0]   mcand;  // multiplicand, or divisor in the low half.
	logic [63:0]   mcand_n;
	logic [31:0]   mplier;
	logic [31:0]   mplier_n;
	logic [32:0]   rem_sh;
	logic [63:0]   prod_fix;
	logic          sgn;
	logic          div_op;
	logic          long_op;
	logic [31:0]   a_mag;
	logic [31:0]   b_mag;

	assign sgn     = (op == xalu_mult) || (op == xalu_div);
	assign div_op  = (op == xalu_div) || (op == xalu_divu);
	assign long_op = op inside {xalu_mult, xalu_multu, xalu_div, xalu_divu};
	assign a_mag   = (sgn && a[31]) ? -a : a;
	assign b_mag   = (sgn && b[31]) ? -b : b;

	always_comb begin
		work_n   = work;
		mcand_n  = mcand;
		mplier_n = mplier;
		nbits_n  = nbits;
		rem_sh   = 33'h0;
		for (int i = 0; i < steps; i++) begin
			if (nbits_n < 6'd32) begin // extra steps idle when cyc does not divide 32.
				if (is_div) begin
					rem_sh = {work_n[63:32], work_n[31]};
					work_n = work_n << 1;
					if (rem_sh >= {1'b0, mcand_n[31:0]}) begin
						work_n[63:32] = rem_sh[31:0] - mcand_n[31:0];
						work_n[0] = 1'b1;
					end
				end else begin
					if (mplier_n[0])
						work_n = work_n + mcand_n;
					mcand_n  = mcand_n << 1;
					mplier_n = mplier_n >> 1;
				end
				nbits_n = nbits_n + 6'd1;
			end
		end
	end

	assign prod_fix = neg_lo ? -work_n : work_n;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			hi   <= 32'h0;
			lo   <= 32'h0;
		end else if (start) begin
			case (op)
				xalu_mthi: hi <= a;
				xalu_mtlo: lo <= a;
				default: begin
					busy <= long_op;
					cnt  <= cw'(cyc);
				end
			endcase
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == cw'(1)) begin
				busy <= 1'b0;
				if (is_div) begin
					lo <= neg_lo ? -work_n[31:0] : work_n[31:0];
					hi <= neg_hi ? -work_n[63:32] : work_n[63:32]; // sign of the dividend.
				end else begin
					hi <= prod_fix[63:32];
					lo <= prod_fix[31:0];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			is_div <= div_op;
			neg_lo <= sgn && (a[31] ^ b[31]);
			neg_hi <= sgn && a[31];
			nbits  <= 6'd0;
			work   <= div_op ? {32'h0, a_mag} : 64'h0;
			mcand  <= {32'h0, div_op ? b_mag : a_mag};
			mplier <= b_mag;
		end else if (busy) begin
			work   <= work_n;
			mcand  <= mcand_n;
			mplier <= mplier_n;
			nbits  <= nbits_n;
		end
	end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  exec_pkg::alu_op_e op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [4:0]        shamt,
	output logic [31:0]       y,
	output logic              ovf
);
	import exec_pkg::*;

	logic [32:0] sum;
	logic [32:0] diff;

	// one extra sign bit; the two top bits disagree on overflow.
	assign sum  = {a[31], a} + {b[31], b};
	assign diff = {a[31], a} - {b[31], b};

	always_comb begin
		case (op)
			alu_add: y = sum[31:0];
			alu_sub: y = diff[31:0];
			alu_and: y = a & b;
			alu_or: y = a | b;
			alu_xor: y = a ^ b;
			alu_nor: y = ~(a | b);
			alu_slt: y = {31'h0, $signed(a) < $signed(b)};
			alu_sltu: y = {31'h0, a < b};
			alu_lui: y = {b[15:0], 16'h0};
			alu_sll: y = b << shamt;
			alu_srl: y = b >> shamt;
			alu_sra: y = $signed(b) >>> shamt;
			alu_pass_b: y = b;
			default: y = 32'h0;
		endcase
	end

	always_comb begin
		case (op)
			alu_add: ovf = sum[32] ^ sum[31];
			alu_sub: ovf = diff[32] ^ diff[31];
			default: ovf = 1'b0;
		endcase
	end

endmodule

// ==== rtl/ctrl_e.sv ====
`timescale 1ns/1ns

module ctrl_e (
	input  exec_pkg::alu_op_e  alu_op,
	input  exec_pkg::xalu_op_e xalu_op,
	input  logic               chk_ovf,
	input  logic               is_movz,
	input  logic               is_movn,
	input  logic               writes,
	input  logic [31:0]        rt_val,
	input  logic               alu_ovf,
	output logic               xalu_start,
	output logic               wr_en,
	output exec_pkg::exc_e     exc
);
	import exec_pkg::*;

	logic rt_zero;
	logic mov_squash;
	logic ovf_hit;
	logic div_zero;

	assign rt_zero = (rt_val == 32'h0);

	// movz fires only on a zero rt, movn only on a nonzero one.
	assign mov_squash = (is_movz && !rt_zero) || (is_movn && rt_zero);

	assign ovf_hit  = chk_ovf && alu_ovf && (alu_op inside {alu_add, alu_sub});
	assign div_zero = (xalu_op inside {xalu_div, xalu_divu}) && rt_zero;

	// a zero divisor never reaches the unit, so hi and lo keep their value.
	assign xalu_start = (xalu_op != xalu_none) && !div_zero;

	always_comb begin
		if (ovf_hit)
			exc = exc_overflow;
		else if (div_zero)
			exc = exc_div_zero;
		else
			exc = exc_none;
	end

	assign wr_en = writes && !mov_squash && (exc == exc_none);

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns
`include "mips_defs.svh"

module instr_decoder (
	input  mips_isa_pkg::instr_u   ir,
	output exec_pkg::alu_op_e      alu_op,
	output exec_pkg::xalu_op_e     xalu_op,
	output exec_pkg::res_sel_e     res_sel,
	output logic                   b_imm,
	output logic                   imm_signed,
	output logic                   shift_var,
	output logic                   chk_ovf,
	output logic                   is_movz,
	output logic                   is_movn,
	output mips_isa_pkg::reg_idx_t dest,
	output logic                   writes
);
	import exec_pkg::*;

	logic r_type;

	assign r_type = (ir.r.op == `OP_SPECIAL);

	always_comb begin
		alu_op = alu_none;
		if (r_type) begin
			case (ir.r.funct)
				`FN_ADD, `FN_ADDU: alu_op = alu_add;
				`FN_SUB, `FN_SUBU: alu_op = alu_sub;
				`FN_AND: alu_op = alu_and;
				`FN_OR: alu_op = alu_or;
				`FN_XOR: alu_op = alu_xor;
				`FN_NOR: alu_op = alu_nor;
				`FN_SLT: alu_op = alu_slt;
				`FN_SLTU: alu_op = alu_sltu;
				`FN_SLL, `FN_SLLV: alu_op = alu_sll;
				`FN_SRL, `FN_SRLV: alu_op = alu_srl;
				`FN_SRA, `FN_SRAV: alu_op = alu_sra;
				`FN_MOVZ, `FN_MOVN: alu_op = alu_pass_b; // rs is steered onto b.
				default: alu_op = alu_none;
			endcase
		end else begin
			case (ir.i.op)
				`OP_ADDI, `OP_ADDIU: alu_op = alu_add;
				`OP_SLTI: alu_op = alu_slt;
				`OP_SLTIU: alu_op = alu_sltu;
				`OP_ANDI: alu_op = alu_and;
				`OP_ORI: alu_op = alu_or;
				`OP_XORI: alu_op = alu_xor;
				`OP_LUI: alu_op = alu_lui;
				default: alu_op = alu_none;
			endcase
		end
	end

	always_comb begin
		xalu_op = xalu_none;
		if (r_type) begin
			case (ir.r.funct)
				`FN_MULT: xalu_op = xalu_mult;
				`FN_MULTU: xalu_op = xalu_multu;
				`FN_DIV: xalu_op = xalu_div;
				`FN_DIVU: xalu_op = xalu_divu;
				`FN_MTHI: xalu_op = xalu_mthi;
				`FN_MTLO: xalu_op = xalu_mtlo;
				default: xalu_op = xalu_none;
			endcase
		end
	end

	assign res_sel = !r_type ? res_alu :
	                 (ir.r.funct == `FN_MFHI) ? res_hi :
	                 (ir.r.funct == `FN_MFLO) ? res_lo : res_alu;

	assign b_imm      = !r_type;
	assign imm_signed = ir.i.op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
	assign shift_var  = r_type && (ir.r.funct inside {`FN_SLLV, `FN_SRLV, `FN_SRAV});
	assign chk_ovf    = r_type ? (ir.r.funct inside {`FN_ADD, `FN_SUB}) : (ir.i.op == `OP_ADDI);
	assign is_movz    = r_type && (ir.r.funct == `FN_MOVZ);
	assign is_movn    = r_type && (ir.r.funct == `FN_MOVN);
	assign dest       = r_type ? ir.r.rd : ir.i.rt;

	// hi/lo moves and unknown words leave the register file alone.
	assign writes = (alu_op != alu_none) || (res_sel != res_alu);

endmodule

// ==== common/exec_pkg.sv ====
package exec_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_lui,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b,
		alu_none
	} alu_op_e;

	typedef enum logic [2:0] {
		xalu_none,
		xalu_mult,
		xalu_multu,
		xalu_div,
		xalu_divu,
		xalu_mthi,
		xalu_mtlo
	} xalu_op_e;

	typedef enum logic [1:0] {exc_none, exc_overflow, exc_div_zero} exc_e;

	typedef enum logic [1:0] {res_alu, res_hi, res_lo} res_sel_e;

endpackage

// ==== common/mips_isa_pkg.sv ====
`include "mips_defs.svh"

package mips_isa_pkg;

	typedef logic [4:0] reg_idx_t;

	// register format, fields keep their position in the word.
	typedef struct packed {
		logic [`F_OP]    op;
		logic [`F_RS]    rs;
		logic [`F_RT]    rt;
		logic [`F_RD]    rd;
		logic [`F_SHAMT] shamt;
		logic [`F_FUNCT] funct;
	} instr_r_t;

	typedef struct packed {
		logic [`F_OP] op;
		logic [`F_RS] rs;
		logic [`F_RT] rt;
		logic [15:0]  imm;
	} instr_i_t;

	// the same word seen both ways.
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

// ==== common/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// bit ranges of the instruction fields.
`define F_OP    31:26
`define F_RS    25:21
`define F_RT    20:16
`define F_RD    15:11
`define F_SHAMT 10:6
`define F_FUNCT 5:0

`define OP_SPECIAL 6'h00
`define OP_ADDI    6'h08
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f

`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_SRA   6'h03
`define FN_SLLV  6'h04
`define FN_SRLV  6'h06
`define FN_SRAV  6'h07
`define FN_MOVZ  6'h0a
`define FN_MOVN  6'h0b
`define FN_MFHI  6'h10
`define FN_MTHI  6'h11
`define FN_MFLO  6'h12
`define FN_MTLO  6'h13
`define FN_MULT  6'h18
`define FN_MULTU 6'h19
`define FN_DIV   6'h1a
`define FN_DIVU  6'h1b
`define FN_ADD   6'h20
`define FN_ADDU  6'h21
`define FN_SUB   6'h22
`define FN_SUBU  6'h23
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_XOR   6'h26
`define FN_NOR   6'h27
`define FN_SLT   6'h2a
`define FN_SLTU  6'h2b

`define XALU_CYCLES 32 // cycles a multiply or divide keeps the unit busy.

`endif
